//--- gamepad_tests.txt
# columns: mode (0 nes, 1 snes), pressed mask in wire order, expected buttons
# buttons msb first: a b select start up down left right x y shoulder_l shoulder_r
0 000 000
0 0ff ff0
0 001 800
0 002 400
0 004 200
0 008 100
0 010 080
0 020 040
0 040 020
0 080 010
0 05a 5a0
1 000 000
1 fff fff
1 001 400
1 002 004
1 100 800
1 200 008
1 400 002
1 800 001
1 0a5 650
1 3c3 c3c

//--- all.f
gamepad_pkg.sv
pad_bit_timer.sv
pad_sequencer.sv
pad_button_capture.sv
gamepad_receiver.sv
tb_gamepad_receiver.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_gamepad_receiver
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ns -Wno-fatal
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_gamepad_receiver.sv
// gamepad receiver testbench: gamepad model, file driven and random frames, link timing checks
`timescale 1ns/1ns

module tb_gamepad_receiver;

    localparam int HALF_BIT = 4;
    // clock pulses per frame on the wire
    localparam int NES_CLOCKS = 8;
    localparam int SNES_CLOCKS = 16;
    // a full snes frame is 17 periods, leave plenty of slack
    localparam int WAIT_LIMIT = 40 * 2 * HALF_BIT;
    localparam int RANDOM_TESTS = 6;

    logic                  clk_50;
    logic                  reset;
    logic                  data;
    logic                  is_snes;
    logic                  controller_latch;
    logic                  controller_clk;
    gamepad_pkg::buttons_t buttons;
    logic                  frame_valid;

    // gamepad model state, pressed mask in wire order
    logic [15:0] pad_mask;
    logic [15:0] pad_shift = 16'hffff;
    logic        clk_prev = 1'b1;

    int                    errors;
    int                    err_mark;
    int                    tests_run;
    int                    tests_failed;
    logic                  timed_out;
    logic [15:0]           lfsr;
    gamepad_pkg::buttons_t last_expected;

    gamepad_receiver #(
        .HALF_BIT(HALF_BIT)
    ) u_gamepad_receiver (
        .clk_50          (clk_50),
        .reset           (reset),
        .data            (data),
        .is_snes         (is_snes),
        .controller_latch(controller_latch),
        .controller_clk  (controller_clk),
        .buttons         (buttons),
        .frame_valid     (frame_valid)
    );

    initial begin
        clk_50 = 1'b0;
        forever #4 clk_50 = ~clk_50;
    end

    // 16 bit shift register like the real pad
    // loads while latch is high, shifts on a rising pad clock, released bits are 1
    always @(negedge clk_50) begin
        if (controller_latch) begin
            pad_shift <= ~pad_mask;
        end else if (controller_clk && !clk_prev) begin
            pad_shift <= {1'b1, pad_shift[15:1]};
        end
        clk_prev <= controller_clk;
    end

    assign data = pad_shift[0];

    // 16 bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // mask bit i is wire bit i, pressed = 1
    function automatic gamepad_pkg::buttons_t expected_for(input logic snes,
                                                           input logic [11:0] mask);
        gamepad_pkg::buttons_t b;
        b = '0;
        if (snes) begin
            b.b          = mask[0];
            b.y          = mask[1];
            b.select     = mask[2];
            b.start      = mask[3];
            b.up         = mask[4];
            b.down       = mask[5];
            b.left       = mask[6];
            b.right      = mask[7];
            b.a          = mask[8];
            b.x          = mask[9];
            b.shoulder_l = mask[10];
            b.shoulder_r = mask[11];
        end else begin
            b.a      = mask[0];
            b.b      = mask[1];
            b.select = mask[2];
            b.start  = mask[3];
            b.up     = mask[4];
            b.down   = mask[5];
            b.left   = mask[6];
            b.right  = mask[7];
        end
        return b;
    endfunction

    task automatic take_random_mask(output logic [11:0] mask);
        for (int i = 0; i < 12; i++) begin
            lfsr = lfsr_next(lfsr);
            mask[i] = lfsr[0];
        end
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("ERROR %s: got %0h expected %0h", name, got, expected);
            errors++;
        end
    endtask

    task automatic start_test();
        err_mark = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end
    endtask

    // returns on the first falling clk_50 edge with the latch at level
    task automatic wait_latch(input logic level);
        int n;
        n = 0;
        while (!timed_out && controller_latch != level) begin
            @(negedge clk_50);
            n++;
            if (n >= WAIT_LIMIT && controller_latch != level) begin
                $display("timeout: controller_latch never went to %0d", level);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    // follows one frame up to the next latch rise
    // counts pad clock pulses, latch width and frame_valid width, checks the published buttons
    task automatic watch_frame(input gamepad_pkg::buttons_t expected, input int clocks,
                               input logic from_latch);
        int                    n;
        int                    falls;
        int                    latch_cycles;
        int                    valid_cycles;
        logic                  in_latch;
        logic                  prev_clk;
        logic                  prev_latch;
        logic                  got_valid;
        logic                  done;
        logic                  held_ok;
        gamepad_pkg::buttons_t held_bad;
        gamepad_pkg::buttons_t held_want;
        n = 0;
        falls = 0;
        latch_cycles = from_latch ? 1 : 0;
        valid_cycles = 0;
        in_latch = from_latch;
        prev_clk = controller_clk;
        prev_latch = controller_latch;
        got_valid = 1'b0;
        done = 1'b0;
        held_ok = 1'b1;
        held_bad = '0;
        held_want = '0;
        while (!done && !timed_out) begin
            @(negedge clk_50);
            n++;
            if (in_latch && controller_latch) begin
                latch_cycles++;
            end else begin
                in_latch = 1'b0;
            end
            if (prev_clk && !controller_clk) begin
                falls++;
            end
            if (frame_valid) begin
                valid_cycles++;
            end
            // old value until frame_valid, new value after it
            if (frame_valid && !got_valid) begin
                got_valid = 1'b1;
                check_value("buttons", int'(buttons), int'(expected));
            end else if (held_ok && buttons != (got_valid ? expected : last_expected)) begin
                held_ok = 1'b0;
                held_bad = buttons;
                held_want = got_valid ? expected : last_expected;
            end
            if (controller_latch && !prev_latch) begin
                done = 1'b1;
            end
            prev_clk = controller_clk;
            prev_latch = controller_latch;
            if (!done && n >= WAIT_LIMIT) begin
                $display("timeout: no latch rise ended the frame");
                timed_out = 1'b1;
                errors++;
            end
        end
        if (!timed_out) begin
            // one single cycle strobe per frame
            check_value("frame_valid high cycles", valid_cycles, 1);
            assert (held_ok) else begin
                $display("ERROR buttons: got %0h expected %0h while holding",
                         held_bad, held_want);
                errors++;
            end
            if (from_latch) begin
                check_value("controller_latch high cycles", latch_cycles, 2 * HALF_BIT);
            end
            check_value("controller_clk falling edges", falls, clocks);
        end
        last_expected = expected;
    endtask

    // new inputs land between latches, the following frame must use them
    task automatic run_test(input string name, input logic mode, input logic [11:0] mask,
                            input gamepad_pkg::buttons_t expected);
        start_test();
        wait_latch(1'b0);
        is_snes <= mode;
        pad_mask <= {4'h0, mask};
        wait_latch(1'b1);
        watch_frame(expected, mode ? SNES_CLOCKS : NES_CLOCKS, 1'b1);
        finish_test(name);
    endtask

    task automatic run_file_tests();
        int                    fd;
        int                    code;
        int                    line_no;
        int                    fields;
        string                 line;
        logic [3:0]            mode;
        logic [11:0]           mask;
        gamepad_pkg::buttons_t expected;
        fd = $fopen("gamepad_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open gamepad_tests.txt");
            errors++;
        end else begin
            line_no = 0;
            while (!$feof(fd) && !timed_out) begin
                line = "";
                code = $fgets(line, fd);
                line_no++;
                // comment and blank lines give no fields
                fields = (code == 0) ? 0 : $sscanf(line, "%h %h %h", mode, mask, expected);
                if (fields == 3) begin
                    run_test($sformatf("file line %0d mode %0d mask %03h", line_no, mode, mask),
                             mode[0], mask, expected);
                end
            end
            $fclose(fd);
        end
    endtask

    // mode flips after the latch, current frame keeps the old mode
    task automatic run_mode_change();
        logic old_mode;
        start_test();
        wait_latch(1'b0);
        old_mode = is_snes;
        is_snes <= !old_mode;
        watch_frame(last_expected, old_mode ? SNES_CLOCKS : NES_CLOCKS, 1'b0);
        watch_frame(expected_for(!old_mode, pad_mask[11:0]),
                    old_mode ? NES_CLOCKS : SNES_CLOCKS, 1'b1);
        finish_test($sformatf("mode change to %0d mid-frame", !old_mode));
    endtask

    // pad mask changes after the load, buttons keep the last frame
    task automatic run_hold_check(input logic [11:0] new_mask);
        logic mode;
        start_test();
        wait_latch(1'b0);
        mode = is_snes;
        pad_mask <= {4'h0, new_mask};
        watch_frame(last_expected, mode ? SNES_CLOCKS : NES_CLOCKS, 1'b0);
        watch_frame(expected_for(mode, new_mask), mode ? SNES_CLOCKS : NES_CLOCKS, 1'b1);
        finish_test("buttons hold over mid-frame mask change");
    endtask

    initial begin
        logic        mode;
        logic [11:0] mask;
        reset = 1'b1;
        is_snes = 1'b0;
        pad_mask = '0;
        errors = 0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        lfsr = 16'h0002;
        last_expected = '0;

        // link idles with latch low and clock high
        start_test();
        repeat (4) begin
            @(negedge clk_50);
            check_value("controller_latch", int'(controller_latch), 0);
            check_value("controller_clk", int'(controller_clk), 1);
            check_value("buttons", int'(buttons), 0);
            check_value("frame_valid", int'(frame_valid), 0);
        end
        reset <= 1'b0;
        // latch comes up on the first edge out of reset
        @(negedge clk_50);
        check_value("controller_latch", int'(controller_latch), 1);
        check_value("controller_clk", int'(controller_clk), 1);
        finish_test("reset state");

        run_file_tests();

        for (int i = 0; i < RANDOM_TESTS; i++) begin
            mode = (i % 3) != 2;
            take_random_mask(mask);
            run_test($sformatf("random %0d mode %0d mask %03h", i, mode, mask),
                     mode, mask, expected_for(mode, mask));
        end

        run_mode_change();
        run_mode_change();
        run_hold_check(12'h5a3);

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- gamepad_receiver.sv
// nes/snes gamepad receiver top: timer, sequencer and button capture
`timescale 1ns/1ns

module gamepad_receiver #(
    parameter int HALF_BIT = gamepad_pkg::DEFAULT_HALF_BIT
) (
    input  logic                  clk_50,
    input  logic                  reset,
    input  logic                  data,
    input  logic                  is_snes,
    output logic                  controller_latch,
    output logic                  controller_clk,
    output gamepad_pkg::buttons_t buttons,
    output logic                  frame_valid
);

    // timer to sequencer
    logic timer_run;
    logic half_high;
    logic sample_strobe;
    logic period_end;

    // sequencer to capture
    logic shift_en;
    logic frame_done;
    logic snes_frame;

    pad_bit_timer #(
        .HALF_BIT(HALF_BIT)
    ) u_pad_bit_timer (
        .clk_50       (clk_50),
        .reset        (reset),
        .run          (timer_run),
        .half_high    (half_high),
        .sample_strobe(sample_strobe),
        .period_end   (period_end)
    );

    pad_sequencer u_pad_sequencer (
        .clk_50          (clk_50),
        .reset           (reset),
        .is_snes         (is_snes),
        .half_high       (half_high),
        .sample_strobe   (sample_strobe),
        .period_end      (period_end),
        .timer_run       (timer_run),
        .controller_latch(controller_latch),
        .controller_clk  (controller_clk),
        .shift_en        (shift_en),
        .frame_done      (frame_done),
        .snes_frame      (snes_frame)
    );

    // button register and frame strobe live in the capture block
    pad_button_capture u_pad_button_capture (
        .clk_50     (clk_50),
        .reset      (reset),
        .data       (data),
        .shift_en   (shift_en),
        .frame_done (frame_done),
        .snes_frame (snes_frame),
        .buttons    (buttons),
        .frame_valid(frame_valid)
    );

endmodule

//--- pad_button_capture.sv
// gamepad button capture: shifts in sampled bits and decodes them by mode at frame end
`timescale 1ns/1ns

module pad_button_capture (
    input  logic                  clk_50,
    input  logic                  reset,
    input  logic                  data,
    input  logic                  shift_en,
    input  logic                  frame_done,
    input  logic                  snes_frame,
    output gamepad_pkg::buttons_t buttons,
    output logic                  frame_valid
);

    gamepad_pkg::raw_bits_t raw;
    gamepad_pkg::raw_bits_t pressed;
    gamepad_pkg::buttons_t  decoded;
    logic [gamepad_pkg::NES_READ_BITS-1:0] nes_pressed;

    // shift right, new bit enters at the top
    // after 12 shifts the first bit sits in bit 0
    always_ff @(posedge clk_50) begin
        if (shift_en) begin
            raw <= {data, raw[gamepad_pkg::SNES_READ_BITS-1:1]};
        end
    end

    // wire is active low
    assign pressed = ~raw;

    // nes frame is only 8 shifts, so its bits sit in the upper part
    assign nes_pressed = pressed[gamepad_pkg::SNES_READ_BITS-1 -: gamepad_pkg::NES_READ_BITS];

    always_comb begin
        decoded = '0;
        if (snes_frame) begin
            // snes order: B Y select start up down left right A X L R
            decoded.b          = pressed[0];
            decoded.y          = pressed[1];
            decoded.select     = pressed[2];
            decoded.start      = pressed[3];
            decoded.up         = pressed[4];
            decoded.down       = pressed[5];
            decoded.left       = pressed[6];
            decoded.right      = pressed[7];
            decoded.a          = pressed[8];
            decoded.x          = pressed[9];
            decoded.shoulder_l = pressed[10];
            decoded.shoulder_r = pressed[11];
        end else begin
            // nes order: A B select start up down left right
            decoded.a      = nes_pressed[0];
            decoded.b      = nes_pressed[1];
            decoded.select = nes_pressed[2];
            decoded.start  = nes_pressed[3];
            decoded.up     = nes_pressed[4];
            decoded.down   = nes_pressed[5];
            decoded.left   = nes_pressed[6];
            decoded.right  = nes_pressed[7];
        end
    end

    // publish once per frame, hold until the next one
    always_ff @(posedge clk_50) begin
        if (reset) begin
            buttons     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= frame_done;
            if (frame_done) begin
                buttons <= decoded;
            end
        end
    end

endmodule

//--- pad_sequencer.sv
// gamepad frame sequencer FSM: latch, read and padding periods with registered link outputs
`timescale 1ns/1ns

module pad_sequencer (
    input  logic clk_50,
    input  logic reset,
    input  logic is_snes,
    input  logic half_high,
    input  logic sample_strobe,
    input  logic period_end,
    output logic timer_run,
    output logic controller_latch,
    output logic controller_clk,
    output logic shift_en,
    output logic frame_done,
    output logic snes_frame
);

    // last read index per mode
    localparam gamepad_pkg::bit_idx_t NES_LAST =
        gamepad_pkg::bit_idx_t'(gamepad_pkg::NES_READ_BITS - 1);
    localparam gamepad_pkg::bit_idx_t SNES_LAST =
        gamepad_pkg::bit_idx_t'(gamepad_pkg::SNES_READ_BITS - 1);
    // last padding period of an snes frame
    localparam gamepad_pkg::bit_idx_t PAD_LAST =
        gamepad_pkg::bit_idx_t'(gamepad_pkg::SNES_TOTAL_CLOCKS - 1);

    gamepad_pkg::seq_state_t state;
    gamepad_pkg::bit_idx_t   bit_idx;
    logic                    last_read;

    // final read period of the frame in the captured mode
    assign last_read = snes_frame ? (bit_idx == SNES_LAST) : (bit_idx == NES_LAST);

    // timer only runs in a legal state
    // an illegal encoding parks it until the FSM is back in st_latch
    assign timer_run = (state == gamepad_pkg::st_latch) ||
                       (state == gamepad_pkg::st_read) ||
                       (state == gamepad_pkg::st_pad);

    // shift on the mid-period sample of read periods only
    assign shift_en = sample_strobe && (state == gamepad_pkg::st_read);

    always_ff @(posedge clk_50) begin
        if (reset) begin
            state            <= gamepad_pkg::st_latch;
            bit_idx          <= '0;
            snes_frame       <= 1'b0;
            controller_latch <= 1'b0;
            // idle level of the gamepad clock is high
            controller_clk   <= 1'b1;
            frame_done       <= 1'b0;
        end else begin
            // link outputs lag the timer by one cycle
            controller_latch <= (state == gamepad_pkg::st_latch);
            // clock held high through the latch period
            controller_clk   <= (state == gamepad_pkg::st_latch) || half_high;
            frame_done       <= (state == gamepad_pkg::st_read) && period_end && last_read;

            // first latch cycle, latch output not yet up
            if ((state == gamepad_pkg::st_latch) && !controller_latch) begin
                snes_frame <= is_snes;
            end

            case (state)
                gamepad_pkg::st_latch: begin
                    if (period_end) begin
                        state   <= gamepad_pkg::st_read;
                        bit_idx <= '0;
                    end
                end
                gamepad_pkg::st_read: begin
                    if (period_end) begin
                        // index keeps counting into the snes padding
                        bit_idx <= bit_idx + 1'b1;
                        if (last_read) begin
                            state <= snes_frame ? gamepad_pkg::st_pad : gamepad_pkg::st_latch;
                        end
                    end
                end
                gamepad_pkg::st_pad: begin
                    if (period_end) begin
                        if (bit_idx == PAD_LAST) begin
                            state <= gamepad_pkg::st_latch;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    // recover from a corrupt encoding
                    state   <= gamepad_pkg::st_latch;
                    bit_idx <= '0;
                end
            endcase
        end
    end

endmodule

//--- pad_bit_timer.sv
// bit period timer: gamepad clock level, mid-period sample strobe and period end strobe
`timescale 1ns/1ns

module pad_bit_timer #(
    parameter int HALF_BIT = gamepad_pkg::DEFAULT_HALF_BIT
) (
    input  logic clk_50,
    input  logic reset,
    input  logic run,
    output logic half_high,
    output logic sample_strobe,
    output logic period_end
);

    // count where the low half starts
    localparam gamepad_pkg::half_cnt_t HALF_CNT = gamepad_pkg::half_cnt_t'(HALF_BIT);
    // last count of the period
    localparam gamepad_pkg::half_cnt_t END_CNT = gamepad_pkg::half_cnt_t'(2 * HALF_BIT - 1);

    gamepad_pkg::half_cnt_t cnt;

    // free running while run is high, wraps every bit period
    always_ff @(posedge clk_50) begin
        if (reset) begin
            cnt <= '0;
        end else if (!run) begin
            // parked at period start
            cnt <= '0;
        end else if (period_end) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // first half of the period is high
    assign half_high = (cnt < HALF_CNT);

    // first cycle of the low half, data is stable here
    assign sample_strobe = run && (cnt == HALF_CNT);

    // one cycle pulse on the last count before wrap
    assign period_end = run && (cnt == END_CNT);

endmodule

//--- gamepad_pkg.sv
// gamepad receiver shared types: widths, button struct, sequencer states, timing constants
package gamepad_pkg;

    // default half bit period in clk_50 cycles
    // 300 cycles is 6 us at 50 MHz
    localparam int DEFAULT_HALF_BIT = 300;

    // protocol frame lengths in bit periods
    localparam int NES_READ_BITS = 8;
    localparam int SNES_READ_BITS = 12;
    // snes adds padding clocks after the read bits
    localparam int SNES_TOTAL_CLOCKS = 16;

    // cycle count within one bit period, holds up to 2*300
    typedef logic [10:0] half_cnt_t;

    // bit period index within a frame, 0..15
    typedef logic [3:0] bit_idx_t;

    // sampled bits as sent on the wire
    // bit 0 is the first bit, active low
    typedef logic [SNES_READ_BITS-1:0] raw_bits_t;

    // decoded buttons, pressed = 1
    typedef struct packed {
        logic a;
        logic b;
        logic select;
        logic start;
        logic up;
        logic down;
        logic left;
        logic right;
        // snes only, zero for nes
        logic x;
        logic y;
        logic shoulder_l;
        logic shoulder_r;
    } buttons_t;

    // sequencer FSM states
    typedef enum logic [1:0] {
        st_latch,
        st_read,
        st_pad
    } seq_state_t;

endpackage
